// ==== Bender.yml ====
package:
  name: gb_timer

export_include_dirs:
  - .

sources:
  - files:
      - gb_timer_pkg.sv
      - mmio_bus_decoder.sv
      - div_prescaler.sv
      - tima_counter.sv
      - interrupt_ctrl.sv
      - gb_timer_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_gb_timer.sv

// ==== div_prescaler.sv ====
/* Counts every clock; any DIV write clears all 16 bits.
   The clear can cause an extra TIMA tick, as on the real part. */

`timescale 1ns/1ps

module div_prescaler
    import gb_timer_pkg::*;
(
    input  logic       I_CLOCK,
    input  logic       I_RESET,
    input  logic       div_wr,
    output sys_count_t sys_count,
    output data_t      div_val
);

    sys_count_t count_q;

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            count_q <= '0;
        end else if (div_wr) begin
            // Written data is ignored
            count_q <= '0;
        end else begin
            count_q <= count_q + 16'd1;
        end
    end

    assign sys_count = count_q;

    // DIV is the upper byte
    assign div_val = count_q[15:8];

endmodule

// ==== files.f ====
+incdir+.
gb_timer_pkg.sv
mmio_bus_decoder.sv
div_prescaler.sv
tima_counter.sv
interrupt_ctrl.sv
gb_timer_top.sv
tb_gb_timer.sv

// ==== gb_timer_pkg.sv ====
/* Shared vector types for the timer block and its bus. */

package gb_timer_pkg;

    // CPU address bus
    typedef logic [15:0] addr_t;

    // Register contents and bus data
    typedef logic [7:0] data_t;

    // Free-running system counter, DIV is the upper byte
    typedef logic [15:0] sys_count_t;

    // Timer control
    // bit 2 enables TIMA, bits 1:0 pick the rate
    typedef logic [2:0] tac_t;

endpackage

// ==== gb_timer_settings.svh ====
/* Register map and TAC tap positions for the timer block.
   Tap positions assume one system counter tick per I_CLOCK. */

`ifndef GB_TIMER_SETTINGS_SVH
`define GB_TIMER_SETTINGS_SVH

// Interrupt flag and enable registers
`define MMIO_IF   16'hff0f
`define MMIO_IE   16'hffff

// Timer registers
`define MMIO_DIV  16'hff04
`define MMIO_TIMA 16'hff05
`define MMIO_TMA  16'hff06
`define MMIO_TAC  16'hff07

// System counter bit watched for each TAC rate code
// 00 gives a period of 1024 clocks
`define TAC_BIT_00 9

// 01 gives a period of 16 clocks
`define TAC_BIT_01 3

// 10 gives a period of 64 clocks
`define TAC_BIT_10 5

// 11 gives a period of 256 clocks
`define TAC_BIT_11 7

`endif

// ==== gb_timer_top.sv ====
/* Split read and write data, no tristate bus.
   From a TIMA wrap, irq follows two edges later when IE bit 2 is set. */

`timescale 1ns/1ps

module gb_timer_top
    import gb_timer_pkg::*;
(
    input  logic  I_CLOCK,
    input  logic  I_RESET,
    input  addr_t addr,
    input  data_t wdata,
    input  logic  re_l,
    input  logic  we_l,
    output data_t rdata,
    output logic  irq
);

    logic       div_wr;
    logic       tima_wr;
    logic       tma_wr;
    logic       tac_wr;
    logic       if_wr;
    logic       ie_wr;
    data_t      div_val;
    data_t      tima_val;
    data_t      tma_val;
    tac_t       tac_val;
    data_t      if_val;
    data_t      ie_val;
    sys_count_t sys_count;
    logic       overflow;

    mmio_bus_decoder u_decoder (
        .addr     (addr),
        .re_l     (re_l),
        .we_l     (we_l),
        .div_val  (div_val),
        .tima_val (tima_val),
        .tma_val  (tma_val),
        .tac_val  (tac_val),
        .if_val   (if_val),
        .ie_val   (ie_val),
        .div_wr   (div_wr),
        .tima_wr  (tima_wr),
        .tma_wr   (tma_wr),
        .tac_wr   (tac_wr),
        .if_wr    (if_wr),
        .ie_wr    (ie_wr),
        .rdata    (rdata)
    );

    div_prescaler u_prescaler (
        .I_CLOCK   (I_CLOCK),
        .I_RESET   (I_RESET),
        .div_wr    (div_wr),
        .sys_count (sys_count),
        .div_val   (div_val)
    );

    tima_counter u_timer (
        .I_CLOCK   (I_CLOCK),
        .I_RESET   (I_RESET),
        .sys_count (sys_count),
        .wdata     (wdata),
        .tima_wr   (tima_wr),
        .tma_wr    (tma_wr),
        .tac_wr    (tac_wr),
        .tima_val  (tima_val),
        .tma_val   (tma_val),
        .tac_val   (tac_val),
        .overflow  (overflow)
    );

    interrupt_ctrl u_intc (
        .I_CLOCK  (I_CLOCK),
        .I_RESET  (I_RESET),
        .wdata    (wdata),
        .if_wr    (if_wr),
        .ie_wr    (ie_wr),
        .overflow (overflow),
        .if_val   (if_val),
        .ie_val   (ie_val),
        .irq      (irq)
    );

endmodule

// ==== interrupt_ctrl.sv ====
/* Only the timer source (IF bit 2) is wired; other flags are set by CPU writes.
   irq is a level and stays high until the CPU clears the flag. */

`timescale 1ns/1ps

module interrupt_ctrl
    import gb_timer_pkg::*;
(
    input  logic  I_CLOCK,
    input  logic  I_RESET,
    input  data_t wdata,
    input  logic  if_wr,
    input  logic  ie_wr,
    input  logic  overflow,
    output data_t if_val,
    output data_t ie_val,
    output logic  irq
);

    logic [4:0] if_q;
    data_t      ie_q;
    logic [4:0] if_next;

    // CPU write first, timer request ORed on top
    always_comb begin
        if_next = if_wr ? wdata[4:0] : if_q;
        if_next[2] = if_next[2] | overflow;
    end

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            if_q <= '0;
            ie_q <= '0;
        end else begin
            if_q <= if_next;
            if (ie_wr) begin
                ie_q <= wdata;
            end
        end
    end

    // Unused IF bits read as ones
    assign if_val = {3'b111, if_q};
    assign ie_val = ie_q;

    // Any pending and enabled source
    assign irq = |(if_q & ie_q[4:0]);

endmodule

// ==== mmio_bus_decoder.sv ====
/* Strobes are active-low levels with no handshake.
   Reads are combinational and return 0 when idle or unmapped. */

`timescale 1ns/1ps
`include "gb_timer_settings.svh"

module mmio_bus_decoder
    import gb_timer_pkg::*;
(
    input  addr_t addr,
    input  logic  re_l,
    input  logic  we_l,
    input  data_t div_val,
    input  data_t tima_val,
    input  data_t tma_val,
    input  tac_t  tac_val,
    input  data_t if_val,
    input  data_t ie_val,
    output logic  div_wr,
    output logic  tima_wr,
    output logic  tma_wr,
    output logic  tac_wr,
    output logic  if_wr,
    output logic  ie_wr,
    output data_t rdata
);

    logic hit_div;
    logic hit_tima;
    logic hit_tma;
    logic hit_tac;
    logic hit_if;
    logic hit_ie;
    logic write_en;

    // Address match per register
    assign hit_div  = (addr == `MMIO_DIV);
    assign hit_tima = (addr == `MMIO_TIMA);
    assign hit_tma  = (addr == `MMIO_TMA);
    assign hit_tac  = (addr == `MMIO_TAC);
    assign hit_if   = (addr == `MMIO_IF);
    assign hit_ie   = (addr == `MMIO_IE);

    assign write_en = ~we_l;

    // Write pulses, sampled by the owners at the next rising edge
    assign div_wr  = write_en & hit_div;
    assign tima_wr = write_en & hit_tima;
    assign tma_wr  = write_en & hit_tma;
    assign tac_wr  = write_en & hit_tac;
    assign if_wr   = write_en & hit_if;
    assign ie_wr   = write_en & hit_ie;

    // Read multiplexer
    always_comb begin
        rdata = 8'h00;
        if (!re_l) begin
            if (hit_div) begin
                rdata = div_val;
            end else if (hit_tima) begin
                rdata = tima_val;
            end else if (hit_tma) begin
                rdata = tma_val;
            end else if (hit_tac) begin
                // Only three TAC bits exist
                rdata = {5'b00000, tac_val};
            end else if (hit_if) begin
                rdata = if_val;
            end else if (hit_ie) begin
                rdata = ie_val;
            end
        end
    end

endmodule

// ==== tb_gb_timer.sv ====
/* Directed testbench for the timer block. Bus accesses are driven at the
   rising edge and rdata and irq are sampled at the falling edge. */

`timescale 1ns/1ps
`include "gb_timer_settings.svh"

module tb_gb_timer
    import gb_timer_pkg::*;
;

    logic  I_CLOCK = 1'b0;
    logic  I_RESET;
    addr_t addr;
    data_t wdata;
    logic  re_l;
    logic  we_l;
    data_t rdata;
    logic  irq;

    int errors;
    int checks;

    gb_timer_top u_dut (
        .I_CLOCK (I_CLOCK),
        .I_RESET (I_RESET),
        .addr    (addr),
        .wdata   (wdata),
        .re_l    (re_l),
        .we_l    (we_l),
        .rdata   (rdata),
        .irq     (irq)
    );

    always #5 I_CLOCK = ~I_CLOCK;

    // Write lands at the second rising edge, where we_l is seen low
    task automatic bus_write(input addr_t a, input data_t d);
        @(posedge I_CLOCK);
        addr  <= a;
        wdata <= d;
        we_l  <= 1'b0;
        @(posedge I_CLOCK);
        we_l  <= 1'b1;
    endtask

    task automatic bus_read(input addr_t a, output data_t d);
        @(posedge I_CLOCK);
        addr <= a;
        re_l <= 1'b0;
        @(negedge I_CLOCK);
        d = rdata;
    endtask

    task automatic compare_byte(input string test_name, input data_t expected,
                                input data_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    task automatic wait_irq(input string test_name, input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (irq !== level && cycles < limit) begin
            @(negedge I_CLOCK);
            cycles++;
        end
        checks++;
        if (irq !== level) begin
            errors++;
            $display("%s: irq did not go to %b within %0d cycles", test_name, level, limit);
        end
    endtask

    // Timer period in clocks for each TAC rate code
    function automatic int rate_period(input logic [1:0] code);
        case (code)
            2'b00:   rate_period = 2 << `TAC_BIT_00;
            2'b01:   rate_period = 2 << `TAC_BIT_01;
            2'b10:   rate_period = 2 << `TAC_BIT_10;
            default: rate_period = 2 << `TAC_BIT_11;
        endcase
    endfunction

    task automatic test_reset_values();
        data_t rd;
        bus_read(`MMIO_DIV, rd);
        compare_byte("reset_values DIV", 8'h00, rd);
        bus_read(`MMIO_TIMA, rd);
        compare_byte("reset_values TIMA", 8'h00, rd);
        bus_read(`MMIO_TMA, rd);
        compare_byte("reset_values TMA", 8'h00, rd);
        bus_read(`MMIO_TAC, rd);
        compare_byte("reset_values TAC", 8'h00, rd);
        bus_read(`MMIO_IE, rd);
        compare_byte("reset_values IE", 8'h00, rd);
        bus_read(`MMIO_IF, rd);
        compare_byte("reset_values IF", 8'he0, rd);
        compare_byte("reset_values irq", 8'h00, {7'b0, irq});
    endtask

    task automatic test_div_count();
        data_t rd;
        int    k;
        k = 1 + int'($urandom % 20);
        bus_write(`MMIO_DIV, data_t'($urandom));
        repeat (256 * k) @(posedge I_CLOCK);
        bus_read(`MMIO_DIV, rd);
        compare_byte("div_count after wait", data_t'(k), rd);
        bus_write(`MMIO_DIV, 8'h00);
        bus_read(`MMIO_DIV, rd);
        compare_byte("div_count after clear", 8'h00, rd);
    endtask

    task automatic test_tima_rates();
        data_t rd;
        data_t held;
        int    period;
        for (int code = 0; code < 4; code++) begin
            period = rate_period(code[1:0]);
            bus_write(`MMIO_TAC, {5'b0, 1'b1, code[1:0]});
            // Any tick caused by the clear is overwritten by the TIMA write
            bus_write(`MMIO_DIV, 8'h00);
            bus_write(`MMIO_TIMA, 8'h00);
            repeat (8 * period) @(posedge I_CLOCK);
            bus_read(`MMIO_TIMA, rd);
            checks++;
            if (rd !== 8'd8 && rd !== 8'd7) begin
                errors++;
                $display("CHECK FAILED tima_rates code %0d: expected 07 or 08, actual %h",
                         code, rd);
            end
            // Disabled timer holds its value
            bus_write(`MMIO_TAC, {6'b0, code[1:0]});
            bus_read(`MMIO_TIMA, held);
            repeat (2 * period) @(posedge I_CLOCK);
            bus_read(`MMIO_TIMA, rd);
            compare_byte("tima_rates disabled", held, rd);
        end
    endtask

    task automatic test_overflow_reload();
        data_t rd;
        data_t tma_v;
        tma_v = data_t'($urandom);
        bus_write(`MMIO_IF, 8'h00);
        bus_write(`MMIO_TMA, tma_v);
        bus_write(`MMIO_TAC, 8'h05);
        bus_write(`MMIO_DIV, 8'h00);
        bus_write(`MMIO_TIMA, 8'hfe);
        // Ticks land 16 clocks apart, the wrap is the second one
        repeat (40) @(posedge I_CLOCK);
        bus_read(`MMIO_TIMA, rd);
        compare_byte("overflow_reload TIMA", tma_v, rd);
        bus_read(`MMIO_IF, rd);
        compare_byte("overflow_reload IF bit 2", 8'h04, rd & 8'h04);
        bus_write(`MMIO_TAC, 8'h00);
    endtask

    task automatic test_interrupt_ctrl();
        data_t if_v;
        data_t ie_v;
        bus_write(`MMIO_IE, 8'h00);
        bus_write(`MMIO_IF, 8'h04);
        @(negedge I_CLOCK);
        compare_byte("interrupt_ctrl masked", 8'h00, {7'b0, irq});
        bus_write(`MMIO_IE, 8'h04);
        wait_irq("interrupt_ctrl enable", 1'b1, 4);
        bus_write(`MMIO_IF, 8'h00);
        wait_irq("interrupt_ctrl clear", 1'b0, 4);
        for (int i = 0; i < 16; i++) begin
            if_v = data_t'($urandom);
            ie_v = data_t'($urandom);
            bus_write(`MMIO_IF, if_v);
            bus_write(`MMIO_IE, ie_v);
            @(negedge I_CLOCK);
            compare_byte("interrupt_ctrl random", {7'b0, |(if_v[4:0] & ie_v[4:0])},
                         {7'b0, irq});
        end
        bus_write(`MMIO_IF, 8'h00);
        bus_write(`MMIO_IE, 8'h00);
    endtask

    task automatic test_register_rw();
        data_t rd;
        data_t v;
        addr_t a;
        for (int i = 0; i < 8; i++) begin
            v = data_t'($urandom);
            bus_write(`MMIO_TMA, v);
            bus_read(`MMIO_TMA, rd);
            compare_byte("register_rw TMA", v, rd);
            v = data_t'($urandom);
            bus_write(`MMIO_IE, v);
            bus_read(`MMIO_IE, rd);
            compare_byte("register_rw IE", v, rd);
            v = data_t'($urandom);
            bus_write(`MMIO_TAC, v);
            bus_read(`MMIO_TAC, rd);
            compare_byte("register_rw TAC", {5'b0, v[2:0]}, rd);
        end
        // Strobe high gives zero, even with a nonzero TMA addressed
        bus_write(`MMIO_TMA, 8'h5a);
        @(posedge I_CLOCK);
        addr <= `MMIO_TMA;
        re_l <= 1'b1;
        @(negedge I_CLOCK);
        compare_byte("register_rw idle read", 8'h00, rdata);
        bus_read(16'hff08, rd);
        compare_byte("register_rw unmapped ff08", 8'h00, rd);
        a = addr_t'($urandom % 16'h8000);
        bus_read(a, rd);
        compare_byte("register_rw unmapped random", 8'h00, rd);
        bus_write(`MMIO_TAC, 8'h00);
        bus_write(`MMIO_IE, 8'h00);
    endtask

    initial begin
        errors  = 0;
        checks  = 0;
        void'($urandom(32'haf3d));
        I_RESET = 1'b1;
        addr    = '0;
        wdata   = '0;
        re_l    = 1'b1;
        we_l    = 1'b1;
        repeat (2) @(posedge I_CLOCK);
        I_RESET <= 1'b0;

        test_reset_values();
        test_div_count();
        test_tima_rates();
        test_overflow_reload();
        test_interrupt_ctrl();
        test_register_rw();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tima_counter.sv ====
/* TIMA reloads from TMA in the same edge it wraps; the delayed reload
   of the real hardware is not modelled. CPU writes to TIMA win over ticks. */

`timescale 1ns/1ps
`include "gb_timer_settings.svh"

module tima_counter
    import gb_timer_pkg::*;
(
    input  logic       I_CLOCK,
    input  logic       I_RESET,
    input  sys_count_t sys_count,
    input  data_t      wdata,
    input  logic       tima_wr,
    input  logic       tma_wr,
    input  logic       tac_wr,
    output data_t      tima_val,
    output data_t      tma_val,
    output tac_t       tac_val,
    output logic       overflow
);

    tac_t  tac_q;
    data_t tma_q;
    data_t tima_q;
    logic  overflow_q;
    logic  sel_bit;
    logic  tick_level;
    logic  tick_prev_q;
    logic  tick;
    data_t reload_val;

    // Counter tap chosen by the rate code
    always_comb begin
        case (tac_q[1:0])
            2'b00:   sel_bit = sys_count[`TAC_BIT_00];
            2'b01:   sel_bit = sys_count[`TAC_BIT_01];
            2'b10:   sel_bit = sys_count[`TAC_BIT_10];
            default: sel_bit = sys_count[`TAC_BIT_11];
        endcase
    end

    // Clearing the enable while the tap is high also counts as a fall
    assign tick_level = sel_bit & tac_q[2];
    assign tick       = tick_prev_q & ~tick_level;

    // A TMA write in the reload cycle supplies the reload value
    assign reload_val = tma_wr ? wdata : tma_q;

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            tac_q <= '0;
            tma_q <= '0;
        end else begin
            if (tac_wr) begin
                tac_q <= wdata[2:0];
            end
            if (tma_wr) begin
                tma_q <= wdata;
            end
        end
    end

    // Falling edge detector
    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            tick_prev_q <= 1'b0;
        end else begin
            tick_prev_q <= tick_level;
        end
    end

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            tima_q     <= '0;
            overflow_q <= 1'b0;
        end else begin
            overflow_q <= 1'b0;
            if (tima_wr) begin
                tima_q <= wdata;
            end else if (tick) begin
                if (tima_q == 8'hff) begin
                    tima_q     <= reload_val;
                    overflow_q <= 1'b1;
                end else begin
                    tima_q <= tima_q + 8'd1;
                end
            end
        end
    end

    assign tima_val = tima_q;
    assign tma_val  = tma_q;
    assign tac_val  = tac_q;
    assign overflow = overflow_q;

endmodule
